//--- hdl/sram_test_pkg.sv
package sram_test_pkg;

  // number of data patterns in one full run
  localparam int pattern_count = 6;

  // data patterns, applied in this order
  typedef enum logic [2:0] {
    pat_zeros       = 3'd0,
    pat_ones        = 3'd1,
    // bit 0 low, then alternating
    pat_checker_a   = 3'd2,
    // bit 0 high, then alternating
    pat_checker_b   = 3'd3,
    pat_address     = 3'd4,
    pat_address_inv = 3'd5
  } pattern_id_t;

  // test sequencer states
  typedef enum logic [2:0] {
    seq_start      = 3'd0,
    seq_write      = 3'd1,
    seq_write_hold = 3'd2,
    seq_read       = 3'd3,
    seq_read_hold  = 3'd4,
    seq_done       = 3'd5,
    seq_halt       = 3'd7
  } seq_state_t;

  // chip control pins, all active low
  typedef struct packed {
    logic we_n;
    logic oe_n;
    logic ce_n;
  } sram_strobes_t;

endpackage

//--- hdl/addr_iter.sv
`timescale 1ns/1ps

module addr_iter #(
  parameter int ADDR_BITS = 20
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 next,
  output logic [ADDR_BITS-1:0] addr,
  output logic                 last_addr
);

  typedef logic [ADDR_BITS-1:0] addr_t;

  addr_t count;

  // free-running over the whole space, wraps from max back to 0
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      count <= '0;
    end else if (next) begin
      count <= count + addr_t'(1);
    end
  end

  assign addr = count;

  // all ones is the last address
  assign last_addr = &count;

endmodule

//--- hdl/pattern_gen.sv
`timescale 1ns/1ps

module pattern_gen #(
  parameter int ADDR_BITS = 20,
  parameter int DATA_BITS = 16
) (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       restart,
  input  logic                       next,
  input  logic [ADDR_BITS-1:0]       addr,
  output logic [DATA_BITS-1:0]       data,
  output sram_test_pkg::pattern_id_t pattern_id,
  output logic                       last_pattern
);

  // wide enough to hold either the address or a data word
  localparam int EXT_BITS = (ADDR_BITS > DATA_BITS) ? ADDR_BITS : DATA_BITS;

  typedef logic [DATA_BITS-1:0] data_t;
  typedef logic [EXT_BITS-1:0]  ext_t;

  localparam sram_test_pkg::pattern_id_t final_pattern =
    sram_test_pkg::pattern_id_t'(sram_test_pkg::pattern_count - 1);

  ext_t  addr_ext;
  data_t addr_word;
  data_t checker_a;

  // current pattern
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pattern_id <= sram_test_pkg::pat_zeros;
    end else if (restart) begin
      pattern_id <= sram_test_pkg::pat_zeros;
    end else if (next) begin
      if (pattern_id == final_pattern) begin
        pattern_id <= sram_test_pkg::pat_zeros;
      end else begin
        pattern_id <= sram_test_pkg::pattern_id_t'(pattern_id + 3'd1);
      end
    end
  end

  assign last_pattern = (pattern_id == final_pattern);

  // address zero-extended or cut down to the data width
  assign addr_ext  = ext_t'(addr);
  assign addr_word = addr_ext[DATA_BITS-1:0];

  // odd bits set, even bits clear
  always_comb begin
    for (int i = 0; i < DATA_BITS; i++) begin
      checker_a[i] = (i % 2) == 1;
    end
  end

  always_comb begin
    case (pattern_id)
      sram_test_pkg::pat_zeros:       data = '0;
      sram_test_pkg::pat_ones:        data = '1;
      sram_test_pkg::pat_checker_a:   data = checker_a;
      sram_test_pkg::pat_checker_b:   data = ~checker_a;
      sram_test_pkg::pat_address:     data = addr_word;
      sram_test_pkg::pat_address_inv: data = ~addr_word;
      default:                        data = '0;
    endcase
  end

endmodule

//--- hdl/sram_ctrl.sv
`timescale 1ns/1ps

module sram_ctrl #(
  parameter int ADDR_BITS = 20,
  parameter int DATA_BITS = 16
) (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         req,
  input  logic                         write_enable,
  input  logic [ADDR_BITS-1:0]         addr,
  input  logic [DATA_BITS-1:0]         write_data,
  output logic                         ready,
  output logic [DATA_BITS-1:0]         read_data,
  output logic [ADDR_BITS-1:0]         addr_bus,
  output sram_test_pkg::sram_strobes_t strobes,
  inout  wire  [DATA_BITS-1:0]         data_bus
);

  typedef logic [ADDR_BITS-1:0] addr_t;
  typedef logic [DATA_BITS-1:0] data_t;

  localparam sram_test_pkg::sram_strobes_t strobes_idle = '{
    we_n: 1'b1,
    oe_n: 1'b1,
    ce_n: 1'b1
  };

  sram_test_pkg::sram_strobes_t strobes_q;
  addr_t addr_q;
  data_t wdata_q;
  logic  accept;
  logic  active;

  // chip enable marks the cycle of the access itself
  assign active = !strobes_q.ce_n;
  assign accept = req && ready;

  // phase machine
  // ready comes up one cycle after reset, so the first access is taken
  // on the second cycle and accesses then follow every other cycle
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ready     <= 1'b0;
      strobes_q <= strobes_idle;
    end else if (active) begin
      ready     <= 1'b1;
      strobes_q <= strobes_idle;
    end else if (accept) begin
      ready          <= 1'b0;
      strobes_q.ce_n <= 1'b0;
      strobes_q.we_n <= !write_enable;
      strobes_q.oe_n <= write_enable;
    end else begin
      ready <= 1'b1;
    end
  end

  // request payload
  always_ff @(posedge clk) begin
    if (accept) begin
      addr_q  <= addr;
      wdata_q <= write_data;
    end
  end

  // sample the chip at the end of a read cycle
  always_ff @(posedge clk) begin
    if (active && !strobes_q.oe_n) begin
      read_data <= data_bus;
    end
  end

  assign addr_bus = addr_q;
  assign strobes  = strobes_q;

  // drive the bus only while writing
  assign data_bus = !strobes_q.we_n ? wdata_q : {DATA_BITS{1'bz}};

  // no write or output enable without the chip selected
  ce_covers_access: assert property (
    @(posedge clk) disable iff (reset)
    (!strobes.we_n || !strobes.oe_n) |-> !strobes.ce_n
  );

  // bus contention on the chip
  no_we_and_oe: assert property (
    @(posedge clk) disable iff (reset)
    !(!strobes.we_n && !strobes.oe_n)
  );

endmodule

//--- hdl/test_sequencer.sv
`timescale 1ns/1ps

module test_sequencer #(
  parameter int DATA_BITS = 16
) (
  input  logic                      clk,
  input  logic                      reset,
  output logic                      addr_next,
  input  logic                      last_addr,
  output logic                      pattern_next,
  output logic                      pattern_restart,
  input  logic                      last_pattern,
  input  logic [DATA_BITS-1:0]      pattern_data,
  output logic                      write_enable,
  input  logic                      ready,
  input  logic [DATA_BITS-1:0]      read_data,
  output logic                      test_done,
  output logic                      test_pass,
  output sram_test_pkg::seq_state_t seq_state,
  output logic [DATA_BITS-1:0]      last_read_data,
  output logic [DATA_BITS-1:0]      last_expected_data
);

  typedef logic [DATA_BITS-1:0] data_t;

  sram_test_pkg::seq_state_t state;
  sram_test_pkg::seq_state_t next_state;

  // last_addr as seen when the current access was issued
  logic  phase_last;
  data_t pattern_dly;
  data_t expected_inflight;
  logic  read_valid;
  logic  compare_valid;

  always_comb begin
    next_state      = state;
    addr_next       = 1'b0;
    pattern_next    = 1'b0;
    pattern_restart = 1'b0;
    if (!test_pass) begin
      next_state = sram_test_pkg::seq_halt;
    end else begin
      case (state)
        sram_test_pkg::seq_start: begin
          next_state = sram_test_pkg::seq_write;
        end
        sram_test_pkg::seq_write: begin
          addr_next  = 1'b1;
          next_state = sram_test_pkg::seq_write_hold;
        end
        sram_test_pkg::seq_write_hold: begin
          next_state = phase_last ? sram_test_pkg::seq_read : sram_test_pkg::seq_write;
        end
        sram_test_pkg::seq_read: begin
          addr_next  = 1'b1;
          next_state = sram_test_pkg::seq_read_hold;
        end
        sram_test_pkg::seq_read_hold: begin
          if (!phase_last) begin
            next_state = sram_test_pkg::seq_read;
          end else if (last_pattern) begin
            next_state = sram_test_pkg::seq_done;
          end else begin
            pattern_next = 1'b1;
            next_state   = sram_test_pkg::seq_write;
          end
        end
        sram_test_pkg::seq_done: begin
          pattern_restart = 1'b1;
          next_state      = sram_test_pkg::seq_start;
        end
        sram_test_pkg::seq_halt: begin
          next_state = sram_test_pkg::seq_halt;
        end
        default: begin
          next_state = sram_test_pkg::seq_start;
        end
      endcase
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state         <= sram_test_pkg::seq_start;
      phase_last    <= 1'b0;
      read_valid    <= 1'b0;
      compare_valid <= 1'b0;
      test_done     <= 1'b0;
    end else begin
      state <= next_state;
      if (addr_next) begin
        phase_last <= last_addr;
      end
      // read_data holds the finished read one cycle after the hold state
      read_valid    <= (state == sram_test_pkg::seq_read_hold);
      compare_valid <= read_valid && test_pass;
      // no done pulse once a compare has failed
      test_done     <= (state == sram_test_pkg::seq_done) && test_pass;
    end
  end

  // pattern_data already follows the next address by the hold cycle
  always_ff @(posedge clk) begin
    pattern_dly <= pattern_data;
    if (state == sram_test_pkg::seq_read_hold) begin
      expected_inflight <= pattern_dly;
    end
  end

  // compare pair, frozen once the test has failed
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      last_read_data     <= '0;
      last_expected_data <= '0;
    end else if (read_valid && test_pass) begin
      last_read_data     <= read_data;
      last_expected_data <= expected_inflight;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      test_pass <= 1'b1;
    end else if (compare_valid && (last_read_data != last_expected_data)) begin
      test_pass <= 1'b0;
    end
  end

  assign write_enable = (state == sram_test_pkg::seq_write) ||
                        (state == sram_test_pkg::seq_write_hold);
  assign seq_state    = state;

  // only reset gets out of halt
  halt_is_sticky: assert property (
    @(posedge clk) disable iff (reset)
    (state == sram_test_pkg::seq_halt) |=> (state == sram_test_pkg::seq_halt)
  );

  // no stall on ready, so the controller must already be free here
  access_in_step: assert property (
    @(posedge clk) disable iff (reset)
    (state == sram_test_pkg::seq_write || state == sram_test_pkg::seq_read) |-> ready
  );

endmodule

//--- hdl/sram_tester_top.sv
`timescale 1ns/1ps

module sram_tester_top #(
  parameter int ADDR_BITS = 20,
  parameter int DATA_BITS = 16
) (
  input  logic                         clk,
  input  logic                         reset,
  output logic                         test_done,
  output logic                         test_pass,
  output sram_test_pkg::pattern_id_t   pattern_id,
  output sram_test_pkg::seq_state_t    seq_state,
  output logic [DATA_BITS-1:0]         last_read_data,
  output logic [DATA_BITS-1:0]         last_expected_data,
  output logic [ADDR_BITS-1:0]         addr_bus,
  output sram_test_pkg::sram_strobes_t strobes,
  inout  wire  [DATA_BITS-1:0]         data_bus
);

  logic                 req;
  logic                 addr_next;
  logic [ADDR_BITS-1:0] addr;
  logic                 last_addr;
  logic                 pattern_next;
  logic                 pattern_restart;
  logic                 last_pattern;
  logic [DATA_BITS-1:0] pattern_data;
  logic                 write_enable;
  logic                 ready;
  logic [DATA_BITS-1:0] read_data;

  // the sequencer always has an access pending
  assign req = 1'b1;

  addr_iter #(
    .ADDR_BITS(ADDR_BITS)
  ) iter (
    .clk(clk), .reset(reset), .next(addr_next), .addr(addr), .last_addr(last_addr)
  );

  pattern_gen #(
    .ADDR_BITS(ADDR_BITS), .DATA_BITS(DATA_BITS)
  ) patgen (
    .clk(clk), .reset(reset), .restart(pattern_restart), .next(pattern_next),
    .addr(addr), .data(pattern_data), .pattern_id(pattern_id), .last_pattern(last_pattern)
  );

  test_sequencer #(
    .DATA_BITS(DATA_BITS)
  ) seq (
    .clk(clk), .reset(reset), .addr_next(addr_next), .last_addr(last_addr),
    .pattern_next(pattern_next), .pattern_restart(pattern_restart),
    .last_pattern(last_pattern), .pattern_data(pattern_data),
    .write_enable(write_enable), .ready(ready), .read_data(read_data),
    .test_done(test_done), .test_pass(test_pass), .seq_state(seq_state),
    .last_read_data(last_read_data), .last_expected_data(last_expected_data)
  );

  sram_ctrl #(
    .ADDR_BITS(ADDR_BITS), .DATA_BITS(DATA_BITS)
  ) ctrl (
    .clk(clk), .reset(reset), .req(req), .write_enable(write_enable),
    .addr(addr), .write_data(pattern_data), .ready(ready), .read_data(read_data),
    .addr_bus(addr_bus), .strobes(strobes), .data_bus(data_bus)
  );

endmodule

//--- tests/sram_model.sv
`timescale 1ns/1ps

module sram_model #(
  parameter int ADDR_BITS = 4,
  parameter int DATA_BITS = 16
) (
  input  logic [ADDR_BITS-1:0]         addr,
  input  sram_test_pkg::sram_strobes_t strobes,
  inout  wire  [DATA_BITS-1:0]         data,
  input  logic                         fault_enable,
  input  logic [7:0]                   fault_bit
);

  localparam int depth = 1 << ADDR_BITS;

  logic [DATA_BITS-1:0] mem [depth];
  logic [DATA_BITS-1:0] stuck_mask;
  logic                 reading;
  logic [ADDR_BITS-1:0] wr_addr;
  logic [DATA_BITS-1:0] wr_data;

  // stuck-at-one on one output driver of the chip
  assign stuck_mask = fault_enable ? (DATA_BITS'(1) << fault_bit) : '0;

  assign reading = !strobes.ce_n && !strobes.oe_n && strobes.we_n;
  assign data    = reading ? (mem[addr] | stuck_mask) : {DATA_BITS{1'bz}};

  // address and data follow the pins while the write pulse is low
  always @* begin
    if (!strobes.ce_n && !strobes.we_n && !$isunknown(data)) begin
      wr_addr = addr;
      wr_data = data;
    end
  end

  // the cell takes the word at the end of the write pulse
  always @(posedge strobes.we_n) begin
    mem[wr_addr] <= wr_data;
  end

endmodule

//--- tests/tb_sram_tester.sv
`timescale 1ns/1ps

module tb_sram_tester;

  localparam int ADDR_BITS = 4;
  localparam int DATA_BITS = 16;
  localparam int mem_depth = 1 << ADDR_BITS;
  // one full run plus a little slack
  localparam int run_cycles = sram_test_pkg::pattern_count * (4 * mem_depth + 2) + 8;
  // three runs, rounded up to the next hundred
  localparam int timeout_cycles = ((3 * run_cycles + 99) / 100) * 100;
  localparam int halt_watch_cycles = 40;

  logic                         clk;
  logic                         reset;
  logic                         test_done;
  logic                         test_pass;
  sram_test_pkg::pattern_id_t   pattern_id;
  sram_test_pkg::seq_state_t    seq_state;
  logic [DATA_BITS-1:0]         last_read_data;
  logic [DATA_BITS-1:0]         last_expected_data;
  logic [ADDR_BITS-1:0]         addr_bus;
  sram_test_pkg::sram_strobes_t strobes;
  wire  [DATA_BITS-1:0]         data_bus;
  logic                         fault_enable;
  logic [7:0]                   fault_bit;

  integer seed;
  int     error_count = 0;
  int     check_count = 0;
  int     cycle_count = 0;
  int     done_count = 0;
  int     inject_bit;
  int     inject_delay;
  string  waiting_for = "reset";
  logic   order_check_on = 1'b0;
  logic [DATA_BITS-1:0] fail_word;

  // bus monitor bookkeeping
  logic prev_ce_n = 1'b1;
  logic last_was_write;
  int   wr_idx;
  int   rd_idx;
  int   prev_pid;
  int   patterns_seen;
  int   run_patterns;
  logic fail_found;
  sram_test_pkg::pattern_id_t fail_pid;
  logic [ADDR_BITS-1:0]       fail_addr;

  sram_tester_top #(
    .ADDR_BITS(ADDR_BITS),
    .DATA_BITS(DATA_BITS)
  ) dut (
    .clk(clk), .reset(reset), .test_done(test_done), .test_pass(test_pass),
    .pattern_id(pattern_id), .seq_state(seq_state), .last_read_data(last_read_data),
    .last_expected_data(last_expected_data), .addr_bus(addr_bus), .strobes(strobes),
    .data_bus(data_bus)
  );

  sram_model #(
    .ADDR_BITS(ADDR_BITS),
    .DATA_BITS(DATA_BITS)
  ) sram (
    .addr(addr_bus), .strobes(strobes), .data(data_bus),
    .fault_enable(fault_enable), .fault_bit(fault_bit)
  );

  always #10 clk = ~clk;

  task automatic check(input string name, input logic [31:0] actual,
                       input logic [31:0] expected);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("mismatch %s: got 0x%0h, expected 0x%0h", name, actual, expected);
    end
  endtask

  // data word that a pattern puts at an address
  function automatic logic [DATA_BITS-1:0] expected_word(
    input sram_test_pkg::pattern_id_t pid,
    input logic [ADDR_BITS-1:0]       addr
  );
    logic [63:0]          addr_ext;
    logic [DATA_BITS-1:0] alt;
    addr_ext = 64'(addr);
    // 0 in bit 0, 1 in bit 1, and so on upward
    alt = DATA_BITS'({32{2'b10}});
    case (pid)
      sram_test_pkg::pat_zeros:       return '0;
      sram_test_pkg::pat_ones:        return '1;
      sram_test_pkg::pat_checker_a:   return alt;
      sram_test_pkg::pat_checker_b:   return ~alt;
      sram_test_pkg::pat_address:     return addr_ext[DATA_BITS-1:0];
      sram_test_pkg::pat_address_inv: return ~addr_ext[DATA_BITS-1:0];
      default:                        return '0;
    endcase
  endfunction

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      $display("timeout after %0d cycles: %s", cycle_count, waiting_for);
      $display("checks: %0d, errors: %0d", check_count, error_count + 1);
      $display("TEST FAILED");
      $finish;
    end
  end

  always @(negedge clk) begin : bus_monitor
    logic                 access_start;
    logic [DATA_BITS-1:0] word;
    access_start = !strobes.ce_n && prev_ce_n;
    prev_ce_n = strobes.ce_n;
    if (reset) begin
      last_was_write = 1'b0;
      wr_idx = 0;
      rd_idx = mem_depth;
      prev_pid = 0;
      patterns_seen = 1;
      run_patterns = 0;
      fail_found = 1'b0;
    end else begin
      if (!strobes.we_n) begin
        check("data_bus", data_bus, expected_word(pattern_id, addr_bus));
      end
      // write phase 0..15, then read phase 0..15
      if (order_check_on && access_start) begin
        if (!strobes.we_n) begin
          if (!last_was_write) begin
            check("reads in phase", rd_idx >= mem_depth, 1);
            wr_idx = 0;
          end
          check("write addr_bus", addr_bus, wr_idx);
          wr_idx++;
        end else begin
          if (last_was_write) begin
            check("writes in phase", wr_idx, mem_depth);
            rd_idx = 0;
          end
          // an extra read of address 0 follows the last pattern
          check("read addr_bus", addr_bus, rd_idx % mem_depth);
          rd_idx++;
        end
        last_was_write = !strobes.we_n;
      end
      // first compared read that the stuck bit corrupts
      if (access_start && !strobes.oe_n && fault_enable && !fail_found &&
          seq_state == sram_test_pkg::seq_read_hold) begin
        word = expected_word(pattern_id, addr_bus);
        if (!word[fault_bit]) begin
          fail_found = 1'b1;
          fail_pid = pattern_id;
          fail_addr = addr_bus;
        end
      end
      if (pattern_id != prev_pid) begin
        if (prev_pid == sram_test_pkg::pattern_count - 1 &&
            pattern_id == sram_test_pkg::pat_zeros) begin
          run_patterns = patterns_seen;
          patterns_seen = 1;
        end else begin
          check("pattern_id", pattern_id, prev_pid + 1);
          patterns_seen++;
        end
        prev_pid = pattern_id;
      end
      if (test_done) begin
        done_count++;
        check("test_pass at test_done", test_pass, 1);
        check("patterns in run", run_patterns, sram_test_pkg::pattern_count);
        run_patterns = 0;
      end
    end
  end

  initial begin
    seed = 32'h76fd726c;
    clk = 1'b0;
    reset = 1'b1;
    fault_enable = 1'b0;
    fault_bit = '0;
    @(negedge clk);
    check("test_pass in reset", test_pass, 1);
    check("test_done in reset", test_done, 0);
    check("strobes in reset", strobes, 3'b111);
    check("data_bus released", data_bus === {DATA_BITS{1'bz}}, 1);
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    order_check_on <= 1'b1;

    // two complete runs on a clean memory
    waiting_for = "test_done did not pulse twice, the test never completed";
    while (done_count < 2) begin
      @(posedge clk);
    end
    order_check_on <= 1'b0;

    inject_bit = $unsigned($random(seed)) % DATA_BITS;
    inject_delay = $unsigned($random(seed)) % 200;
    repeat (inject_delay) @(posedge clk);
    fault_bit <= 8'(inject_bit);
    fault_enable <= 1'b1;

    waiting_for = "test_pass never fell after the fault was injected";
    @(negedge clk);
    while (test_pass) begin
      @(negedge clk);
    end
    if (!fail_found) begin
      error_count++;
      $display("test_pass fell although no compared read hit the stuck bit");
    end else begin
      fail_word = expected_word(fail_pid, fail_addr);
      check("last_expected_data", last_expected_data, fail_word);
      check("last_read_data", last_read_data, fail_word | (DATA_BITS'(1) << inject_bit));
    end

    // seq_state follows test_pass one cycle later
    waiting_for = "halt watch did not finish";
    check("test_done after failure", test_done, 0);
    repeat (halt_watch_cycles) begin
      @(negedge clk);
      check("seq_state", seq_state, sram_test_pkg::seq_halt);
      check("test_done after failure", test_done, 0);
      check("test_pass after failure", test_pass, 0);
    end

    @(posedge clk);
    reset <= 1'b1;
    fault_enable <= 1'b0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    check("test_pass after reset", test_pass, 1);
    check("seq_state after reset", seq_state, sram_test_pkg::seq_start);
    @(posedge clk);
    reset <= 1'b0;
    repeat (20) @(posedge clk);
    @(negedge clk);
    check("test_pass after restart", test_pass, 1);

    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- project.f
hdl/sram_test_pkg.sv
hdl/addr_iter.sv
hdl/pattern_gen.sv
hdl/sram_ctrl.sv
hdl/test_sequencer.sv
hdl/sram_tester_top.sv
tests/sram_model.sv
tests/tb_sram_tester.sv
